/* include/qsim_params.svh */
`ifndef QSIM_PARAMS_SVH
`define QSIM_PARAMS_SVH

// --------------------
// number format
// --------------------

// one Q16.16 component, one word
`define QSIM_DATA_W      32
`define QSIM_FRAC_BITS   16

// --------------------
// problem limits
// --------------------

`define QSIM_MAX_QUBITS  3
`define QSIM_MAX_GATES   4

// --------------------
// memory address widths
// --------------------

`define QSIM_STATE_AW    4
// msb picks the half
`define QSIM_SCRATCH_AW  4
`define QSIM_GATE_AW     8

// last read issue to write
`define QSIM_PIPE_DEPTH  3

`endif

/* source/qsim_num_pkg.sv */
`include "qsim_params.svh"

package qsim_num_pkg;

  // --------------------
  // fixed point values
  // --------------------

  // signed Q16.16
  typedef logic signed [`QSIM_DATA_W-1:0] fixed_t;

  // memory word layout, re sits in the upper half
  typedef struct packed {
    fixed_t re;
    fixed_t im;
  } cplx_t;

  // --------------------
  // memory write requests
  // --------------------

  // output memory
  typedef struct packed {
    logic                      en;
    logic [`QSIM_STATE_AW-1:0] addr;
    cplx_t                     data;
  } state_wr_t;

  // scratchpad, addr msb is the half
  typedef struct packed {
    logic                        en;
    logic [`QSIM_SCRATCH_AW-1:0] addr;
    cplx_t                       data;
  } scratch_wr_t;

endpackage

/* source/qsim_ctrl_pkg.sv */
`include "qsim_params.svh"

package qsim_ctrl_pkg;

  // --------------------
  // sequencer FSM
  // --------------------

  typedef enum logic [2:0] {
    SEQ_IDLE,
    SEQ_HEADER,
    SEQ_HEADER_WAIT,
    SEQ_STREAM,
    SEQ_DRAIN
  } seq_state_e;

  // --------------------
  // per term control
  // --------------------

  // accumulator opcode that rides with each term
  typedef enum logic [1:0] {
    ACC_IDLE,
    ACC_START,
    ACC_ADD,
    ACC_END
  } acc_op_e;

  // where the state operand comes from
  typedef enum logic {
    SRC_INPUT,
    SRC_SCRATCH
  } src_e;

  // where a finished row goes
  typedef enum logic {
    DEST_SCRATCH,
    DEST_OUTPUT
  } dest_e;

  typedef struct packed {
    acc_op_e                     op;
    src_e                        src;
    dest_e                       dest;
    logic [`QSIM_MAX_QUBITS-1:0] row;
    logic                        wr_half;
  } mac_tag_t;

endpackage

/* source/gate_sequencer.sv */
`include "qsim_params.svh"

module gate_sequencer
  import qsim_num_pkg::*;
  import qsim_ctrl_pkg::*;
(
  input  logic                        clk,
  input  logic                        reset_n,
  input  logic                        dut_valid,
  output logic                        dut_ready,
  input  cplx_t                       state_rdata,
  output logic [`QSIM_STATE_AW-1:0]   state_raddr,
  output logic [`QSIM_SCRATCH_AW-1:0] scratch_raddr,
  output logic [`QSIM_GATE_AW-1:0]    gate_raddr,
  output mac_tag_t                    tag
);

  localparam int ROW_W  = `QSIM_MAX_QUBITS;
  localparam int QW     = $clog2(`QSIM_MAX_QUBITS + 1);
  localparam int MW     = $clog2(`QSIM_MAX_GATES + 1);
  localparam int GATE_W = $clog2(`QSIM_MAX_GATES);
  localparam int DRN_W  = $clog2(`QSIM_PIPE_DEPTH);

  localparam logic [ROW_W:0] ONE_N = 1;

  seq_state_e state;
  seq_state_e next_state;

  logic [QW-1:0]            q_reg;
  logic [MW-1:0]            m_reg;
  logic [GATE_W-1:0]        gate_cnt;
  logic [ROW_W-1:0]         row_cnt;
  logic [ROW_W-1:0]         col_cnt;
  logic [DRN_W-1:0]         drain_cnt;
  logic [`QSIM_GATE_AW-1:0] gate_addr;

  logic [ROW_W:0]   n_full;
  logic [ROW_W-1:0] last_idx;
  logic             col_last;
  logic             row_last;
  logic             gate_last;
  logic             drain_done;

  // N - 1 from the captured qubit count
  assign n_full     = ONE_N << q_reg;
  assign last_idx   = ROW_W'(n_full - ONE_N);
  assign col_last   = (col_cnt == last_idx);
  assign row_last   = (row_cnt == last_idx);
  assign gate_last  = (MW'(gate_cnt) + 1'b1 == m_reg);
  assign drain_done = (drain_cnt == DRN_W'(`QSIM_PIPE_DEPTH - 1));

  // --------------------
  // FSM
  // --------------------

  always_comb begin
    next_state = state;
    case (state)
      SEQ_IDLE: begin
        if (dut_valid) begin
          next_state = SEQ_HEADER;
        end
      end
      SEQ_HEADER:      next_state = SEQ_HEADER_WAIT;
      SEQ_HEADER_WAIT: next_state = SEQ_STREAM;
      SEQ_STREAM: begin
        if (col_last && row_last) begin
          next_state = SEQ_DRAIN;
        end
      end
      SEQ_DRAIN: begin
        // wait until the last row of this gate has landed
        if (drain_done) begin
          next_state = gate_last ? SEQ_IDLE : SEQ_STREAM;
        end
      end
      default: next_state = SEQ_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state     <= SEQ_IDLE;
      q_reg     <= '0;
      m_reg     <= '0;
      gate_cnt  <= '0;
      row_cnt   <= '0;
      col_cnt   <= '0;
      drain_cnt <= '0;
      gate_addr <= '0;
    end else begin
      state <= next_state;
      case (state)
        SEQ_HEADER_WAIT: begin
          // header word: re = Q, im = M
          q_reg     <= QW'(state_rdata.re);
          m_reg     <= MW'(state_rdata.im);
          gate_cnt  <= '0;
          row_cnt   <= '0;
          col_cnt   <= '0;
          gate_addr <= '0;
        end
        SEQ_STREAM: begin
          // gate memory is walked in plain order g, r, c
          gate_addr <= gate_addr + 1'b1;
          drain_cnt <= '0;
          if (col_last) begin
            col_cnt <= '0;
            row_cnt <= row_last ? '0 : row_cnt + 1'b1;
          end else begin
            col_cnt <= col_cnt + 1'b1;
          end
        end
        SEQ_DRAIN: begin
          drain_cnt <= drain_cnt + 1'b1;
          if (drain_done && !gate_last) begin
            gate_cnt <= gate_cnt + 1'b1;
          end
        end
        default: ;
      endcase
    end
  end

  // --------------------
  // read addresses and tag
  // --------------------

  assign dut_ready = (state == SEQ_IDLE);

  // input state starts at address 1, header at 0
  assign state_raddr = (state == SEQ_STREAM) ?
                       `QSIM_STATE_AW'(col_cnt) + 1'b1 : '0;

  // previous gate wrote the other half
  assign scratch_raddr = {~gate_cnt[0], col_cnt};
  assign gate_raddr    = gate_addr;

  always_comb begin
    tag.op      = ACC_IDLE;
    tag.src     = (gate_cnt == '0) ? SRC_INPUT : SRC_SCRATCH;
    tag.dest    = gate_last ? DEST_OUTPUT : DEST_SCRATCH;
    tag.row     = row_cnt;
    tag.wr_half = gate_cnt[0];
    if (state == SEQ_STREAM) begin
      if (col_cnt == '0) begin
        tag.op = ACC_START;
      end else if (col_last) begin
        tag.op = ACC_END;
      end else begin
        tag.op = ACC_ADD;
      end
    end
  end

  // header must describe a supported problem
  a_header_q: assert property (@(posedge clk) disable iff (!reset_n)
    (state == SEQ_HEADER_WAIT) |->
      (state_rdata.re >= 1 && state_rdata.re <= `QSIM_MAX_QUBITS));

  a_header_m: assert property (@(posedge clk) disable iff (!reset_n)
    (state == SEQ_HEADER_WAIT) |->
      (state_rdata.im >= 1 && state_rdata.im <= `QSIM_MAX_GATES));

endmodule

/* source/complex_mac.sv */
`include "qsim_params.svh"

module complex_mac
  import qsim_num_pkg::*;
  import qsim_ctrl_pkg::*;
(
  input  logic     clk,
  input  logic     reset_n,
  input  mac_tag_t tag_in,
  input  cplx_t    state_rdata,
  input  cplx_t    scratch_rdata,
  input  cplx_t    gate_rdata,
  output mac_tag_t tag_out,
  output fixed_t   rr,
  output fixed_t   ii,
  output fixed_t   ri,
  output fixed_t   ir
);

  mac_tag_t tag_d;
  cplx_t    s_val;

  // Q16.16 multiply, arithmetic shift then truncate to one word
  function automatic fixed_t fx_mul(input fixed_t a, input fixed_t b);
    logic signed [2*`QSIM_DATA_W-1:0] p;
    p = a * b;
    return fixed_t'(p >>> `QSIM_FRAC_BITS);
  endfunction

  // --------------------
  // line up with read data
  // --------------------

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      tag_d   <= '0;
      tag_out <= '0;
    end else begin
      tag_d   <= tag_in;
      tag_out <= tag_d;
    end
  end

  // first gate reads the input state, later ones the scratchpad
  assign s_val = (tag_d.src == SRC_INPUT) ? state_rdata : scratch_rdata;

  // --------------------
  // product registers
  // --------------------

  always_ff @(posedge clk) begin
    rr <= fx_mul(s_val.re, gate_rdata.re);
    ii <= fx_mul(s_val.im, gate_rdata.im);
    ri <= fx_mul(s_val.re, gate_rdata.im);
    ir <= fx_mul(s_val.im, gate_rdata.re);
  end

endmodule

/* source/accumulate_writeback.sv */
`include "qsim_params.svh"

module accumulate_writeback
  import qsim_num_pkg::*;
  import qsim_ctrl_pkg::*;
(
  input  logic        clk,
  input  logic        reset_n,
  input  mac_tag_t    tag_in,
  input  fixed_t      rr,
  input  fixed_t      ii,
  input  fixed_t      ri,
  input  fixed_t      ir,
  output scratch_wr_t scratch_wr,
  output state_wr_t   out_wr
);

  cplx_t term;
  cplx_t sum;
  cplx_t acc;
  cplx_t wr_data_q;

  logic [`QSIM_MAX_QUBITS-1:0] row_q;
  logic                        half_q;
  logic                        scratch_en_q;
  logic                        out_en_q;

  // one complex term of G[r][c] * s[c]
  always_comb begin
    term.re = rr - ii;
    term.im = ri + ir;
    sum     = term;
    if (tag_in.op != ACC_START) begin
      sum.re = acc.re + term.re;
      sum.im = acc.im + term.im;
    end
  end

  // --------------------
  // row accumulator
  // --------------------

  always_ff @(posedge clk) begin
    if (tag_in.op != ACC_IDLE) begin
      acc <= sum;
    end
    if (tag_in.op == ACC_END) begin
      wr_data_q <= sum;
      row_q     <= tag_in.row;
      half_q    <= tag_in.wr_half;
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      scratch_en_q <= 1'b0;
      out_en_q     <= 1'b0;
    end else begin
      scratch_en_q <= (tag_in.op == ACC_END) && (tag_in.dest == DEST_SCRATCH);
      out_en_q     <= (tag_in.op == ACC_END) && (tag_in.dest == DEST_OUTPUT);
    end
  end

  // --------------------
  // write requests
  // --------------------

  always_comb begin
    scratch_wr.en   = scratch_en_q;
    scratch_wr.addr = {half_q, row_q};
    scratch_wr.data = wr_data_q;
    out_wr.en       = out_en_q;
    out_wr.addr     = `QSIM_STATE_AW'(row_q);
    out_wr.data     = wr_data_q;
  end

  a_one_dest: assert property (@(posedge clk) disable iff (!reset_n)
    !(scratch_wr.en && out_wr.en));

endmodule

/* source/qsim_top.sv */
`include "qsim_params.svh"

module qsim_top
  import qsim_num_pkg::*;
  import qsim_ctrl_pkg::*;
(
  input  logic                        clk,
  input  logic                        reset_n,

  // start handshake
  input  logic                        dut_valid,
  output logic                        dut_ready,

  // input state memory
  output logic [`QSIM_STATE_AW-1:0]   state_raddr,
  input  cplx_t                       state_rdata,

  // gate memory
  output logic [`QSIM_GATE_AW-1:0]    gate_raddr,
  input  cplx_t                       gate_rdata,

  // scratchpad
  output logic [`QSIM_SCRATCH_AW-1:0] scratch_raddr,
  input  cplx_t                       scratch_rdata,
  output scratch_wr_t                 scratch_wr,

  // output memory
  output state_wr_t                   out_wr
);

  mac_tag_t seq_tag;
  mac_tag_t mac_tag;
  fixed_t   rr;
  fixed_t   ii;
  fixed_t   ri;
  fixed_t   ir;

  gate_sequencer u_seq (
    .clk           (clk),
    .reset_n       (reset_n),
    .dut_valid     (dut_valid),
    .dut_ready     (dut_ready),
    .state_rdata   (state_rdata),
    .state_raddr   (state_raddr),
    .scratch_raddr (scratch_raddr),
    .gate_raddr    (gate_raddr),
    .tag           (seq_tag)
  );

  complex_mac u_mac (
    .clk           (clk),
    .reset_n       (reset_n),
    .tag_in        (seq_tag),
    .state_rdata   (state_rdata),
    .scratch_rdata (scratch_rdata),
    .gate_rdata    (gate_rdata),
    .tag_out       (mac_tag),
    .rr            (rr),
    .ii            (ii),
    .ri            (ri),
    .ir            (ir)
  );

  accumulate_writeback u_wb (
    .clk        (clk),
    .reset_n    (reset_n),
    .tag_in     (mac_tag),
    .rr         (rr),
    .ii         (ii),
    .ri         (ri),
    .ir         (ir),
    .scratch_wr (scratch_wr),
    .out_wr     (out_wr)
  );

endmodule

/* verif/sram_model.sv */
module sram_model #(
  parameter int AW = 4,
  parameter int DW = 64
) (
  input  logic          clk,
  input  logic [AW-1:0] raddr,
  output logic [DW-1:0] rdata,
  input  logic          we,
  input  logic [AW-1:0] waddr,
  input  logic [DW-1:0] wdata
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int DEPTH = 1 << AW;

  logic [DW-1:0] mem [DEPTH];

  // read data one cycle after the address
  always @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
    rdata <= mem[raddr];
  end

  // --------------------
  // backdoor access
  // --------------------

  // only used while the DUT is idle
  task automatic poke(input int a, input logic [DW-1:0] d);
    mem[a] <= d;
  endtask

  function automatic logic [DW-1:0] peek(input int a);
    return mem[a];
  endfunction

  // every word gets a pattern built from its full address
  task automatic fill(input logic [31:0] seed);
    int a;
    for (a = 0; a < DEPTH; a++) begin
      mem[a] <= DW'({seed ^ 32'(a), ~32'(a)});
    end
  endtask

endmodule

/* verif/qsim_tb.sv */
`include "qsim_params.svh"

module qsim_tb
  import qsim_num_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_HALF   = 5;
  localparam int NMAX       = 1 << `QSIM_MAX_QUBITS;
  localparam int GATE_WORDS = 1 << `QSIM_GATE_AW;
  localparam int WORD_W     = 2 * `QSIM_DATA_W;

  // header, then N*N terms and the drain for every gate
  function automatic int run_cycles(input int q, input int m);
    int n;
    n = 1 << q;
    return 8 + m * (n * n + `QSIM_PIPE_DEPTH);
  endfunction

  localparam int TEST_CYCLES = 16 + 6 * 20 + run_cycles(2, 1) + run_cycles(3, 1)
                               + run_cycles(2, 3) + run_cycles(2, 1) + run_cycles(1, 2);
  localparam int WATCHDOG_NS = 2 * TEST_CYCLES * 2 * CLK_HALF;

  logic                        clk;
  logic                        reset_n;
  logic                        dut_valid;
  logic                        dut_ready;
  logic [`QSIM_STATE_AW-1:0]   state_raddr;
  logic [`QSIM_GATE_AW-1:0]    gate_raddr;
  logic [`QSIM_SCRATCH_AW-1:0] scratch_raddr;
  cplx_t                       state_rdata;
  cplx_t                       gate_rdata;
  cplx_t                       scratch_rdata;
  scratch_wr_t                 scratch_wr;
  state_wr_t                   out_wr;

  logic [31:0] lfsr;
  int          out_writes;
  int          scratch_writes;
  int          error_count;
  cplx_t       state_img [NMAX];
  cplx_t       gate_img [GATE_WORDS];
  cplx_t       expected [NMAX];

  // --------------------
  // DUT and memories
  // --------------------

  qsim_top u_dut (
    .clk           (clk),
    .reset_n       (reset_n),
    .dut_valid     (dut_valid),
    .dut_ready     (dut_ready),
    .state_raddr   (state_raddr),
    .state_rdata   (state_rdata),
    .gate_raddr    (gate_raddr),
    .gate_rdata    (gate_rdata),
    .scratch_raddr (scratch_raddr),
    .scratch_rdata (scratch_rdata),
    .scratch_wr    (scratch_wr),
    .out_wr        (out_wr)
  );

  sram_model #(.AW(`QSIM_STATE_AW), .DW(WORD_W)) u_in_mem (
    .clk   (clk),
    .raddr (state_raddr),
    .rdata (state_rdata),
    .we    (1'b0),
    .waddr ('0),
    .wdata ('0)
  );

  sram_model #(.AW(`QSIM_GATE_AW), .DW(WORD_W)) u_gate_mem (
    .clk   (clk),
    .raddr (gate_raddr),
    .rdata (gate_rdata),
    .we    (1'b0),
    .waddr ('0),
    .wdata ('0)
  );

  sram_model #(.AW(`QSIM_SCRATCH_AW), .DW(WORD_W)) u_scratch_mem (
    .clk   (clk),
    .raddr (scratch_raddr),
    .rdata (scratch_rdata),
    .we    (scratch_wr.en),
    .waddr (scratch_wr.addr),
    .wdata (scratch_wr.data)
  );

  sram_model #(.AW(`QSIM_STATE_AW), .DW(WORD_W)) u_out_mem (
    .clk   (clk),
    .raddr ('0),
    .rdata (),
    .we    (out_wr.en),
    .waddr (out_wr.addr),
    .wdata (out_wr.data)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  // write strobes seen by the memories
  always @(posedge clk) begin
    if (!reset_n) begin
      out_writes     <= 0;
      scratch_writes <= 0;
    end else begin
      if (out_wr.en) begin
        out_writes <= out_writes + 1;
      end
      if (scratch_wr.en) begin
        scratch_writes <= scratch_writes + 1;
      end
    end
  end

  // --------------------
  // stimulus and reference
  // --------------------

  // 32-bit Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // 18 bits sign extended, so below 2.0 in magnitude
  function automatic fixed_t random_fixed();
    logic [17:0] bits;
    int          i;
    bits = '0;
    for (i = 0; i < 18; i++) begin
      bits = {bits[16:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
    return {{14{bits[17]}}, bits};
  endfunction

  // full 64-bit product, keep the middle word
  function automatic fixed_t qmul(input fixed_t a, input fixed_t b);
    logic signed [63:0] wide_a;
    logic signed [63:0] wide_b;
    logic signed [63:0] p;
    wide_a = {{32{a[31]}}, a};
    wide_b = {{32{b[31]}}, b};
    p = wide_a * wide_b;
    return p[`QSIM_FRAC_BITS + 31:`QSIM_FRAC_BITS];
  endfunction

  task automatic load_problem(input int q, input int m, input bit identity);
    cplx_t hdr;
    int    n;
    int    a;
    int    g;
    int    r;
    int    c;
    n = 1 << q;
    hdr.re = q;
    hdr.im = m;
    u_in_mem.poke(0, hdr);
    for (a = 0; a < n; a++) begin
      state_img[a].re = random_fixed();
      state_img[a].im = random_fixed();
      u_in_mem.poke(a + 1, state_img[a]);
    end
    for (g = 0; g < m; g++) begin
      for (r = 0; r < n; r++) begin
        for (c = 0; c < n; c++) begin
          a = g * n * n + r * n + c;
          if (identity) begin
            gate_img[a].re = (r == c) ? 32'h0001_0000 : 32'h0;
            gate_img[a].im = '0;
          end else begin
            gate_img[a].re = random_fixed();
            gate_img[a].im = random_fixed();
          end
          u_gate_mem.poke(a, gate_img[a]);
        end
      end
    end
    u_out_mem.fill(32'h0bad_0000);
    u_scratch_mem.fill(32'h5c4a_0000);
  endtask

  // out[r] = sum over c of G[r][c] * s[c], gate after gate
  task automatic compute_expected(input int q, input int m);
    cplx_t cur [NMAX];
    cplx_t acc;
    cplx_t gw;
    int    n;
    int    g;
    int    r;
    int    c;
    n = 1 << q;
    for (c = 0; c < n; c++) begin
      cur[c] = state_img[c];
    end
    for (g = 0; g < m; g++) begin
      for (r = 0; r < n; r++) begin
        acc = '0;
        for (c = 0; c < n; c++) begin
          gw = gate_img[g * n * n + r * n + c];
          acc.re = acc.re + qmul(gw.re, cur[c].re) - qmul(gw.im, cur[c].im);
          acc.im = acc.im + qmul(gw.re, cur[c].im) + qmul(gw.im, cur[c].re);
        end
        expected[r] = acc;
      end
      for (r = 0; r < n; r++) begin
        cur[r] = expected[r];
      end
    end
  endtask

  // --------------------
  // checking
  // --------------------

  task automatic stop_on_failure(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [63:0] exp_v,
                             input logic [63:0] act_v);
    if (exp_v !== act_v) begin
      error_count++;
      stop_on_failure($sformatf("[ERROR] t=%0t %s expected %h actual %h",
                                $time, name, exp_v, act_v));
    end
  endtask

  task automatic compare_outputs(input int q);
    int r;
    for (r = 0; r < (1 << q); r++) begin
      check_value($sformatf("out_mem[%0d]", r), expected[r], u_out_mem.peek(r));
    end
  endtask

  // start one run and wait until dut_ready is back
  task automatic start_and_wait(input int q, input int m, input bit hold_valid);
    int cycles;
    cycles = 0;
    @(posedge clk);
    #1;
    check_value("dut_ready", 64'(1'b1), 64'(dut_ready));
    dut_valid = 1'b1;
    @(posedge clk);
    #1;
    if (!hold_valid) begin
      dut_valid = 1'b0;
    end
    while (!dut_ready) begin
      @(posedge clk);
      #1;
      cycles++;
      if (cycles > 2 * run_cycles(q, m)) begin
        stop_on_failure($sformatf("dut_ready did not return within %0d cycles", cycles));
      end
    end
    dut_valid = 1'b0;
  endtask

  // --------------------
  // directed tests
  // --------------------

  task automatic reset_state_test();
    check_value("dut_ready", 64'(1'b1), 64'(dut_ready));
    check_value("scratch_wr.en", '0, 64'(scratch_wr.en));
    check_value("out_wr.en", '0, 64'(out_wr.en));
    repeat (4) @(posedge clk);
    #1;
    check_value("out_wr count", '0, 64'(out_writes));
    check_value("scratch_wr count", '0, 64'(scratch_writes));
  endtask

  task automatic identity_gate_test();
    int before_out;
    int before_scr;
    int r;
    load_problem(2, 1, 1'b1);
    before_out = out_writes;
    before_scr = scratch_writes;
    start_and_wait(2, 1, 1'b0);
    // identity leaves the state as it was
    for (r = 0; r < 4; r++) begin
      expected[r] = state_img[r];
    end
    compare_outputs(2);
    check_value("out_wr count", 64'(4), 64'(out_writes - before_out));
    check_value("scratch_wr count", '0, 64'(scratch_writes - before_scr));
  endtask

  task automatic random_gate_test();
    int before_out;
    load_problem(3, 1, 1'b0);
    before_out = out_writes;
    start_and_wait(3, 1, 1'b0);
    compute_expected(3, 1);
    compare_outputs(3);
    check_value("out_wr count", 64'(8), 64'(out_writes - before_out));
  endtask

  task automatic gate_chain_test();
    int before_out;
    int before_scr;
    load_problem(2, 3, 1'b0);
    before_out = out_writes;
    before_scr = scratch_writes;
    start_and_wait(2, 3, 1'b0);
    compute_expected(2, 3);
    compare_outputs(2);
    check_value("out_wr count", 64'(4), 64'(out_writes - before_out));
    check_value("scratch_wr count", 64'(8), 64'(scratch_writes - before_scr));
  endtask

  task automatic busy_hold_test();
    int before_out;
    int before_scr;
    load_problem(2, 1, 1'b0);
    before_out = out_writes;
    start_and_wait(2, 1, 1'b1);
    // a second run would pull dut_ready low here
    repeat (6) @(posedge clk);
    #1;
    check_value("dut_ready", 64'(1'b1), 64'(dut_ready));
    check_value("out_wr count", 64'(4), 64'(out_writes - before_out));
    compute_expected(2, 1);
    compare_outputs(2);
    load_problem(1, 2, 1'b0);
    before_out = out_writes;
    before_scr = scratch_writes;
    start_and_wait(1, 2, 1'b0);
    compute_expected(1, 2);
    compare_outputs(1);
    check_value("out_wr count", 64'(2), 64'(out_writes - before_out));
    check_value("scratch_wr count", 64'(2), 64'(scratch_writes - before_scr));
  endtask

  initial begin
    #(WATCHDOG_NS);
    stop_on_failure($sformatf("timeout, the run did not finish within %0d ns", WATCHDOG_NS));
  end

  initial begin
    reset_n     = 1'b0;
    dut_valid   = 1'b0;
    error_count = 0;
    lfsr        = 32'd1;
    repeat (16) @(posedge clk);
    #1;
    reset_n = 1'b1;
    reset_state_test();
    identity_gate_test();
    random_gate_test();
    gate_chain_test();
    busy_hold_test();
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* list.f */
+incdir+include
source/qsim_num_pkg.sv
source/qsim_ctrl_pkg.sv
source/gate_sequencer.sv
source/complex_mac.sv
source/accumulate_writeback.sv
source/qsim_top.sv
verif/sram_model.sv
verif/qsim_tb.sv

/* Makefile */
# Verilator build and run for the quantum circuit simulator

VERILATOR ?= verilator
TOP       ?= qsim_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= NO ERRORS

SOURCES := $(wildcard include/*.svh source/*.sv verif/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "simulation passed"; \
	else \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
